/* fifo_sc.f */
logic/fifo_pkg.sv
logic/fifo_mem_if.sv
logic/fifo_ram.sv
logic/fifo_ptr_ctrl.sv
logic/fifo_rd_flag.sv
logic/fifo_sc.sv
dv/fifo_sc_checker.sv
dv/fifo_sc_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the FIFO testbench with Verilator, once per data enable mode

result=0

for mode in 0 1
do
	obj="obj_mode${mode}"
	log="sim_mode${mode}.log"

	echo "Building mode ${mode}"
	verilator --binary --timescale 1ns/10ps --top-module fifo_sc_tb \
		-Gmode=${mode} --Mdir "${obj}" -f fifo_sc.f
	if [ $? -ne 0 ]; then
		echo "Verilator build failed for mode ${mode}"
		exit 1
	fi

	"./${obj}/Vfifo_sc_tb" > "${log}" 2>&1
	run_status=$?
	cat "${log}"
	if [ ${run_status} -ne 0 ]; then
		echo "Simulation exited with status ${run_status} in mode ${mode}"
		result=1
	fi

	if grep -q "Test failed" "${log}"; then
		echo "Mode ${mode} FAILED"
		result=1
	else
		echo "Mode ${mode} passed"
	fi
done

exit ${result}

/* dv/fifo_sc_tb.sv */
// FIFO testbench

`timescale 1ns/10ps

module fifo_sc_tb
#(
	parameter int mode = 0	// 0 single, 1 burst
);

	import fifo_pkg::*;

	localparam int         adr_width   = DEF_ADR_WIDTH;
	localparam int         dat_width   = DEF_DAT_WIDTH;
	localparam int         depth       = 2 ** adr_width;
	localparam fifo_mode_e dut_mode    = (mode != 0) ? mode_burst : mode_single;
	localparam int         drain_limit = 4 * depth + 16;	// Cycles

	logic                 clk;
	logic                 rst;
	logic                 clr;
	logic                 wr;
	logic [dat_width-1:0] dat_in;
	logic                 rd_en;
	logic                 rd;
	logic [dat_width-1:0] dat_out;
	logic                 de;
	logic [adr_width:0]   wrds;
	logic                 ep;
	logic                 fl;
	integer               seed;
	bit                   timed_out;
	int                   err_cnt;
	int                   chk_cnt;

	always #2 clk = ~clk;	// 4 ns period

	fifo_sc #(.adr_width (adr_width), .dat_width (dat_width), .mode (dut_mode)) uut
	(
		.RST_IN  (clk),
		.CLK_IN  (rst),
		.clr     (clr),
		.wr      (wr),
		.dat_in  (dat_in),
		.rd_en   (rd_en),
		.rd      (rd),
		.dat_out (dat_out),
		.de      (de),
		.wrds    (wrds),
		.ep      (ep),
		.fl      (fl)
	);

	fifo_sc_checker #(.adr_width (adr_width), .dat_width (dat_width), .mode (dut_mode)) chk
	(
		.clk     (uut.RST_IN),
		.rst     (uut.CLK_IN),
		.clr     (uut.clr),
		.wr      (uut.wr),
		.dat_in  (uut.dat_in),
		.rd_en   (uut.rd_en),
		.rd      (uut.rd),
		.dat_out (uut.dat_out),
		.de      (uut.de),
		.wrds    (uut.wrds),
		.ep      (uut.ep),
		.fl      (uut.fl),
		.err_cnt (err_cnt),
		.chk_cnt (chk_cnt)
	);

	// True with the given chance in percent
	function automatic bit roll_percent(input int pct);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return (r % 100) < pct;
	endfunction

	task automatic run_random(input int cycles, input int wr_pct, input int rd_pct);
		bit do_clr;
		bit room;
		bit want;
		for (int i = 0; i < cycles; i++)
		begin
			@(posedge clk);
			do_clr = roll_percent(1);
			want   = roll_percent(wr_pct);
			// Write lands two edges after fl is seen, keep three words spare
			room   = !fl && (int'(wrds) < depth - 3);
			clr    <= do_clr;
			wr     <= !do_clr && room && want;
			dat_in <= dat_width'($random(seed));
			rd_en  <= roll_percent(88);
			rd     <= roll_percent(rd_pct);
		end
	endtask

	task automatic write_words(input int n, input logic [dat_width-1:0] base);
		for (int i = 0; i < n; i++)
		begin
			@(posedge clk);
			wr     <= 1'b1;
			dat_in <= base + dat_width'(i);
		end
		@(posedge clk);
		wr <= 1'b0;
	endtask

	task automatic wait_empty(input string what);
		int n;
		n = 0;
		do
		begin
			@(posedge clk);
			n++;
		end
		while (ep !== 1'b1 && n < drain_limit);
		if (ep !== 1'b1)
		begin
			$display("Timeout, FIFO still not empty %0d cycles after %s", n, what);
			timed_out = 1'b1;
		end
	endtask

	// Alternate rd so single mode shows every head word before it goes
	task automatic drain_fifo(input string what);
		int n;
		n = 0;
		@(posedge clk);
		clr   <= 1'b0;
		wr    <= 1'b0;
		rd_en <= 1'b1;
		rd    <= 1'b0;
		do
		begin
			@(posedge clk);
			rd <= !rd;
			n++;
		end
		while (ep !== 1'b1 && n < drain_limit);
		rd <= 1'b0;
		if (ep !== 1'b1)
		begin
			$display("Timeout, FIFO did not drain within %0d cycles after %s", n, what);
			timed_out = 1'b1;
		end
	endtask

	task automatic clear_check();
		@(posedge clk);
		rd_en <= 1'b1;
		rd    <= 1'b0;
		write_words(5, 32'ha5a5_0000);	// Thrown away by the clear
		clr <= 1'b1;
		@(posedge clk);
		clr <= 1'b0;
		wait_empty("clear");
		if (!timed_out)
		begin
			write_words(6, 32'hc3c3_0000);
			drain_fifo("clear test");
		end
	endtask

	initial
	begin
		clk       = 1'b0;
		rst       = 1'b1;
		clr       = 1'b0;
		wr        = 1'b0;
		dat_in    = '0;
		rd_en     = 1'b0;
		rd        = 1'b0;
		seed      = 69;
		timed_out = 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		run_random(1500, 70, 30);	// Mostly filling
		run_random(1500, 30, 70);	// Mostly emptying
		run_random(1000, 50, 50);
		drain_fifo("random traffic");
		if (!timed_out)
			clear_check();
		repeat (4) @(posedge clk);
		$display("Checked %0d cycles, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0 && !timed_out)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule : fifo_sc_tb

/* dv/fifo_sc_checker.sv */
// FIFO response checker

`timescale 1ns/10ps

module fifo_sc_checker
#(
	parameter int                   adr_width = fifo_pkg::DEF_ADR_WIDTH,
	parameter int                   dat_width = fifo_pkg::DEF_DAT_WIDTH,
	parameter fifo_pkg::fifo_mode_e mode      = fifo_pkg::mode_single
)
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 clr,
	input  logic                 wr,
	input  logic [dat_width-1:0] dat_in,
	input  logic                 rd_en,
	input  logic                 rd,
	input  logic [dat_width-1:0] dat_out,
	input  logic                 de,
	input  logic [adr_width:0]   wrds,
	input  logic                 ep,
	input  logic                 fl,
	output int                   err_cnt,
	output int                   chk_cnt
);

	import fifo_pkg::*;

	localparam int depth = 2 ** adr_width;

	logic [dat_width-1:0] words [$];		// Model contents, head first
	int                   prev_cnt = 0;		// Count before the last edge
	logic                 exp_de   = 1'b0;
	logic [dat_width-1:0] exp_word = '0;	// Memory output register
	int                   n_err    = 0;
	int                   n_chk    = 0;

	assign err_cnt = n_err;
	assign chk_cnt = n_chk;

	function automatic void reset_model();
		words.delete();
		prev_cnt = 0;	// Word count register keeps clocking in reset
		exp_de   = 1'b0;
	endfunction

	// Reference model, one rising edge
	function automatic void update_model(input logic c_clr, input logic c_wr,
		input logic [dat_width-1:0] c_dat, input logic c_rd_en, input logic c_rd);
		logic                 have;
		logic                 take;
		logic [dat_width-1:0] head;
		have = (words.size() != 0);
		head = have ? words[0] : '0;
		take = c_rd_en && c_rd && have;
		// Flag registers and read data only move with the read clock enable
		if (c_rd_en)
		begin
			if (mode == mode_burst)
				exp_de = take;			// One cycle per accepted read
			else
				exp_de = have && !c_rd;	// Head waiting at the output
			exp_word = head;
		end
		prev_cnt = words.size();
		if (c_clr)
			words.delete();
		else
		begin
			if (take)
				head = words.pop_front();
			if (c_wr)
				words.push_back(c_dat);
		end
	endfunction

	function automatic void compare_bit(input string name, input logic got, input logic want);
		if (got !== want)
		begin
			n_err++;
			$display("ERR %s expected 0x%0h actual 0x%0h at %0t", name, want, got, $time);
		end
	endfunction

	function automatic void compare_word(input string name, input logic [63:0] got,
		input logic [63:0] want);
		if (got !== want)
		begin
			n_err++;
			$display("ERR %s expected 0x%0h actual 0x%0h at %0t", name, want, got, $time);
		end
	endfunction

	function automatic void compare_outputs();
		n_chk++;
		compare_bit("ep", ep, words.size() == 0);
		compare_word("wrds", 64'(wrds), 64'(prev_cnt));	// One cycle behind
		compare_bit("fl", fl, prev_cnt > depth - 2);
		compare_bit("de", de, exp_de);
		if (exp_de && de === 1'b1)
			compare_word("dat_out", 64'(dat_out), 64'(exp_word));
		if (words.size() > depth - 1)
		begin
			n_err++;
			$display("Write into a full FIFO, model holds %0d words at %0t",
				words.size(), $time);
		end
	endfunction

	// Outputs settled at the falling edge, inputs held for the next rising edge
	always @(negedge clk)
	begin
		if (rst)
			reset_model();
		else
		begin
			compare_outputs();
			update_model(clr, wr, dat_in, rd_en, rd);
		end
	end

endmodule : fifo_sc_checker

/* logic/fifo_sc.sv */
// Single clock FIFO

`timescale 1ns/10ps
`default_nettype none

module fifo_sc
#(
	parameter int                   adr_width = fifo_pkg::DEF_ADR_WIDTH,
	parameter int                   dat_width = fifo_pkg::DEF_DAT_WIDTH,
	parameter fifo_pkg::fifo_mode_e mode      = fifo_pkg::mode_single
)
(
	// Clock and reset
	input  logic                 RST_IN,	// Clock
	input  logic                 CLK_IN,	// Reset, asynchronous
	input  logic                 clr,		// Clear

	// Write
	input  logic                 wr,
	input  logic [dat_width-1:0] dat_in,

	// Read
	input  logic                 rd_en,		// Read clock enable
	input  logic                 rd,
	output logic [dat_width-1:0] dat_out,
	output logic                 de,		// Data enable

	// Status
	output logic [adr_width:0]   wrds,		// Used words
	output logic                 ep,		// Empty
	output logic                 fl			// Full
);

	// Pointer control to memory
	fifo_mem_if
	#(
		.adr_width (adr_width),
		.dat_width (dat_width)
	)
	mem_if ();

	// Pointers, flags and word count
	fifo_ptr_ctrl
	#(
		.adr_width (adr_width),
		.dat_width (dat_width)
	)
	ptr_inst
	(
		.RST_IN (RST_IN),
		.CLK_IN (CLK_IN),
		.clr    (clr),
		.wr     (wr),
		.dat_in (dat_in),
		.rd_en  (rd_en),
		.rd     (rd),
		.mem    (mem_if.ctrl),
		.ep     (ep),
		.fl     (fl),
		.wrds   (wrds)
	);

	// Storage
	fifo_ram
	#(
		.adr_width (adr_width),
		.dat_width (dat_width)
	)
	ram_inst
	(
		.RST_IN (RST_IN),
		.mem    (mem_if.mem)
	);

	// Data enable
	fifo_rd_flag
	#(
		.mode (mode)
	)
	flag_inst
	(
		.RST_IN (RST_IN),
		.CLK_IN (CLK_IN),
		.rd_en  (rd_en),
		.rd     (rd),
		.ep     (ep),
		.de     (de)
	);

	// Read data straight from the memory output register
	assign dat_out = mem_if.rd_dat;

endmodule : fifo_sc

`default_nettype wire

/* logic/fifo_rd_flag.sv */
// FIFO data enable generation

`timescale 1ns/10ps
`default_nettype none

module fifo_rd_flag
#(
	parameter fifo_pkg::fifo_mode_e mode = fifo_pkg::mode_single
)
(
	input  logic RST_IN,	// Clock
	input  logic CLK_IN,	// Reset
	input  logic rd_en,		// Read clock enable
	input  logic rd,
	input  logic ep,		// Empty
	output logic de			// Data enable
);

	import fifo_pkg::*;

	logic da_r;		// Data available
	logic rs_r;		// Read strobe, one cycle late

	// Data available
	// Set while the FIFO holds data and nobody reads.
	// Any read drops it until the next word reaches the output
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
			da_r <= 1'b0;
		else
		begin
			if (rd_en)
			begin
				if (ep || rd)
					da_r <= 1'b0;
				else
					da_r <= 1'b1;
			end
		end
	end

	// Delayed read strobe
	// Lines up with the word that the memory registers after the read
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
			rs_r <= 1'b0;
		else
		begin
			if (rd_en)
				rs_r <= rd && !ep;	// Accepted reads only
		end
	end

	// Mode select, fixed at elaboration
	assign de = (mode == mode_burst) ? rs_r : da_r;

endmodule : fifo_rd_flag

`default_nettype wire

/* logic/fifo_ptr_ctrl.sv */
// FIFO pointers and status

`timescale 1ns/10ps
`default_nettype none

module fifo_ptr_ctrl
#(
	parameter int adr_width = fifo_pkg::DEF_ADR_WIDTH,
	parameter int dat_width = fifo_pkg::DEF_DAT_WIDTH
)
(
	input  logic                 RST_IN,	// Clock
	input  logic                 CLK_IN,	// Reset
	input  logic                 clr,		// Synchronous clear

	// Write side
	input  logic                 wr,
	input  logic [dat_width-1:0] dat_in,

	// Read side
	input  logic                 rd_en,		// Read clock enable
	input  logic                 rd,

	// Memory
	fifo_mem_if.ctrl             mem,

	// Status
	output logic                 ep,		// Empty
	output logic                 fl,		// Full
	output logic [adr_width:0]   wrds		// Used words
);

	localparam int depth = 2 ** adr_width;

	localparam logic [adr_width-1:0] ptr_max = adr_width'(depth - 1);
	localparam logic [adr_width:0]   depth_w = (adr_width + 1)'(depth);
	localparam logic [adr_width:0]   fl_thr  = (adr_width + 1)'(depth - 2);

	logic [adr_width-1:0] wp;		// Write pointer
	logic [adr_width-1:0] rp;		// Read pointer
	logic                 rd_ok;	// Accepted read
	logic [adr_width:0]   wrds_nxt;

	// Memory connections
	assign mem.wr     = wr;
	assign mem.wr_dat = dat_in;
	assign mem.wr_adr = wp;
	assign mem.rd_en  = rd_en;
	assign mem.rd_adr = rp;

	// No read from an empty FIFO
	assign rd_ok = rd_en && rd && !ep;

	// Write pointer
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
			wp <= '0;
		else
		begin
			if (clr)
				wp <= '0;
			else if (wr)
			begin
				if (wp == ptr_max)	// Wrap
					wp <= '0;
				else
					wp <= wp + 1'b1;
			end
		end
	end

	// Read pointer
	// Clear wins over the read clock enable
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
			rp <= '0;
		else
		begin
			if (clr)
				rp <= '0;
			else if (rd_ok)
			begin
				if (rp == ptr_max)	// Wrap
					rp <= '0;
				else
					rp <= rp + 1'b1;
			end
		end
	end

	// Empty
	assign ep = (wp == rp);

	// Distance from read to write pointer
	always_comb
	begin
		if (wp >= rp)
			wrds_nxt = {1'b0, wp - rp};
		else
			wrds_nxt = depth_w - {1'b0, rp} + {1'b0, wp};	// Write pointer wrapped
	end

	// Used words, registered for timing
	always_ff @(posedge RST_IN)
	begin
		wrds <= wrds_nxt;
	end

	// Full, leaves one word of margin
	assign fl = (wrds > fl_thr);

endmodule : fifo_ptr_ctrl

`default_nettype wire

/* logic/fifo_ram.sv */
// FIFO simple dual-port memory

`timescale 1ns/10ps
`default_nettype none

module fifo_ram
#(
	parameter int adr_width = fifo_pkg::DEF_ADR_WIDTH,
	parameter int dat_width = fifo_pkg::DEF_DAT_WIDTH
)
(
	input logic    RST_IN,	// Clock
	fifo_mem_if.mem mem
);

	localparam int depth = 2 ** adr_width;

	// Storage array, no reset
	logic [dat_width-1:0] ram [0:depth-1];

	// Write port
	always_ff @(posedge RST_IN)
	begin
		if (mem.wr)
			ram[mem.wr_adr] <= mem.wr_dat;
	end

	// Read port
	// Registered output, one cycle of latency.
	// A write to the same address in the same cycle returns the old word
	always_ff @(posedge RST_IN)
	begin
		if (mem.rd_en)	// Hold last word while disabled
			mem.rd_dat <= ram[mem.rd_adr];
	end

endmodule : fifo_ram

`default_nettype wire

/* logic/fifo_mem_if.sv */
// FIFO memory port bundle

`timescale 1ns/10ps
`default_nettype none

interface fifo_mem_if
#(
	parameter int adr_width = fifo_pkg::DEF_ADR_WIDTH,
	parameter int dat_width = fifo_pkg::DEF_DAT_WIDTH
);

	// Write port
	logic                 wr;
	logic [adr_width-1:0] wr_adr;
	logic [dat_width-1:0] wr_dat;

	// Read port
	logic                 rd_en;	// Read clock enable
	logic [adr_width-1:0] rd_adr;
	logic [dat_width-1:0] rd_dat;	// Registered read data

	// Pointer side
	modport ctrl
	(
		output wr,
		output wr_adr,
		output wr_dat,
		output rd_en,
		output rd_adr,
		input  rd_dat
	);

	// Memory side
	modport mem
	(
		input  wr,
		input  wr_adr,
		input  wr_dat,
		input  rd_en,
		input  rd_adr,
		output rd_dat
	);

	// Read data tap for the top level
	modport top
	(
		input rd_dat
	);

endinterface : fifo_mem_if

`default_nettype wire

/* logic/fifo_pkg.sv */
// Single clock FIFO definitions

package fifo_pkg;

	// Data enable behaviour at the read side
	typedef enum logic [0:0]
	{
		mode_single = 1'b0,	// Data available flag
		mode_burst  = 1'b1	// Delayed read strobe
	} fifo_mode_e;

	// Default geometry
	// Depth is two to the power of the address width
	localparam int DEF_ADR_WIDTH = 4;	// 16 words
	localparam int DEF_DAT_WIDTH = 32;

endpackage : fifo_pkg
